// File: hawk_pkg.sv
////////////////////////////////////////////////////////////
// shared widths, table bases, status codes and entry fields
// for the page-read side; referenced by package::name only
////////////////////////////////////////////////////////////
package hawk_pkg;

  // bus and index widths
  localparam int ADDR_W    = 32;  // axi address
  localparam int DATA_W    = 64;  // axi data, one table entry per beat
  localparam int PAGE_W    = 20;  // page number, address bits 31:12
  localparam int LST_IDX_W = 8;   // tol list index, 0 is null
  localparam int ATT_IDX_W = 10;  // att entry number
  localparam int STS_W     = 2;   // page status code
  localparam int RESP_W    = 2;   // axi rresp

  // first host page, address 0x8000_0000
  localparam logic [PAGE_W-1:0] HPPA_BASE_PAGE = 20'h80000;

  // table bases, entry n sits at base + 8*n
  localparam logic [ADDR_W-1:0] ATT_BASE_ADDR = 32'h0001_0000;
  localparam logic [ADDR_W-1:0] TOL_BASE_ADDR = 32'h0002_0000;

  // page status codes
  localparam logic [STS_W-1:0] STS_DALLOC = 2'd0;  // no physical page yet
  localparam logic [STS_W-1:0] STS_UNCOMP = 2'd1;  // resident, plain
  localparam logic [STS_W-1:0] STS_INCOMP = 2'd2;  // resident, did not compress
  localparam logic [STS_W-1:0] STS_COMP   = 2'd3;  // held compressed

  // att entry layout
  localparam int ENT_STS_LSB  = 0;  // status in 1:0
  localparam int ENT_PAGE_LSB = 8;  // page in 27:8

  // tol entry layout
  localparam int TOL_NEXT_LSB = 0;   // next index in 7:0
  localparam int TOL_WAY_LSB  = 12;  // way page in 31:12

  // axi response
  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

endpackage

// File: hawk_axi_rd_port.sv
////////////////////////////////////////////////////////////
// single-beat axi read master, one read at a time
// start with rd_start/rd_addr, result comes with rd_done
////////////////////////////////////////////////////////////
module hawk_axi_rd_port (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // request side
  input  logic                        rd_start,
  input  logic [hawk_pkg::ADDR_W-1:0] rd_addr,
  output logic                        rd_done,
  output logic                        rd_err,
  output logic [hawk_pkg::DATA_W-1:0] rd_data,
  // axi read channel
  output logic                        arvalid,
  output logic [hawk_pkg::ADDR_W-1:0] araddr,
  input  logic                        arready,
  input  logic                        rvalid,
  input  logic [hawk_pkg::DATA_W-1:0] rdata,
  input  logic [hawk_pkg::RESP_W-1:0] rresp,
  input  logic                        rlast,
  output logic                        rready
);

  logic busy_q;     // read outstanding, from start to data beat
  logic beat;

  assign beat   = rvalid & rready;
  assign rready = busy_q;  // never block the data beat

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arvalid <= 1'b0;
      busy_q  <= 1'b0;
      rd_done <= 1'b0;
      rd_err  <= 1'b0;
    end else begin
      rd_done <= 1'b0;  // one-cycle pulse
      if (rd_start) begin
        arvalid <= 1'b1;
        busy_q  <= 1'b1;
      end else if (arvalid && arready) begin
        arvalid <= 1'b0;  // address taken
      end
      if (beat) begin
        busy_q  <= 1'b0;
        rd_done <= 1'b1;
        rd_err  <= (rresp != hawk_pkg::RESP_OKAY);  // slverr/decerr
      end
    end
  end

  // address and data beat capture
  always_ff @(posedge clk_i) begin
    if (rd_start) araddr <= rd_addr;
    if (beat)     rd_data <= rdata;
  end

  // slave must not answer a read we never issued
  a_rvalid_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid |-> busy_q);
  // single-beat bursts only
  a_single_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat |-> rlast);

endmodule

// File: hawk_att_decoder.sv
////////////////////////////////////////////////////////////
// att side datapath: entry number and address from the page
// number, then status and page of the returned att entry
////////////////////////////////////////////////////////////
module hawk_att_decoder (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           att_load,     // latch lookup page
  input  logic [hawk_pkg::PAGE_W-1:0]    lookup_hppa,
  input  logic                           ent_load,     // capture att entry
  input  logic [hawk_pkg::DATA_W-1:0]    rd_data,
  output logic [hawk_pkg::ATT_IDX_W-1:0] att_idx,
  output logic [hawk_pkg::ADDR_W-1:0]    att_addr,
  output logic [hawk_pkg::STS_W-1:0]     ent_sts,
  output logic [hawk_pkg::PAGE_W-1:0]    ent_page
);

  logic [hawk_pkg::PAGE_W-1:0] rel_page;  // page offset from base, plus one

  // entry numbers start at 1, entry 0 unused
  assign rel_page = lookup_hppa - hawk_pkg::HPPA_BASE_PAGE + 1'b1;

  // byte address of the entry, 8 bytes each
  assign att_addr = hawk_pkg::ATT_BASE_ADDR
                  + {{(hawk_pkg::ADDR_W-hawk_pkg::ATT_IDX_W-3){1'b0}}, att_idx, 3'b000};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      att_idx  <= '0;
      ent_sts  <= hawk_pkg::STS_DALLOC;
      ent_page <= '0;
    end else begin
      if (att_load) begin
        att_idx <= rel_page[hawk_pkg::ATT_IDX_W-1:0];  // table only spans low bits
      end
      if (ent_load) begin
        ent_sts  <= rd_data[hawk_pkg::ENT_STS_LSB +: hawk_pkg::STS_W];
        ent_page <= rd_data[hawk_pkg::ENT_PAGE_LSB +: hawk_pkg::PAGE_W];
      end
    end
  end

endmodule

// File: hawk_tol_alloc.sv
////////////////////////////////////////////////////////////
// free-list pop: tol address from the sampled head, then
// the way page and next index for the table-update packet
////////////////////////////////////////////////////////////
module hawk_tol_alloc (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [hawk_pkg::LST_IDX_W-1:0] free_head,   // level from list manager
  input  logic                           head_load,   // sample free_head
  input  logic                           tol_load,    // capture tol entry
  input  logic [hawk_pkg::DATA_W-1:0]    rd_data,
  output logic [hawk_pkg::ADDR_W-1:0]    tol_addr,
  output logic                           free_empty,
  output logic [hawk_pkg::LST_IDX_W-1:0] upd_tol_idx,
  output logic [hawk_pkg::PAGE_W-1:0]    upd_way,
  output logic [hawk_pkg::LST_IDX_W-1:0] upd_next_head
);

  logic [hawk_pkg::LST_IDX_W-1:0] head_q;  // entry being popped

  // tol entry of the head, 8 bytes per entry
  assign tol_addr = hawk_pkg::TOL_BASE_ADDR
                  + {{(hawk_pkg::ADDR_W-hawk_pkg::LST_IDX_W-3){1'b0}}, head_q, 3'b000};

  assign upd_tol_idx = head_q;  // the popped entry is the one updated

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q     <= '0;
      free_empty <= 1'b1;
    end else if (head_load) begin
      head_q     <= free_head;
      free_empty <= (free_head == '0);  // null head, nothing to allocate
    end
  end

  // packet fields, only meaningful after tol_load
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      upd_way       <= '0;
      upd_next_head <= '0;
    end else if (tol_load) begin
      upd_way       <= rd_data[hawk_pkg::TOL_WAY_LSB +: hawk_pkg::PAGE_W];
      upd_next_head <= rd_data[hawk_pkg::TOL_NEXT_LSB +: hawk_pkg::LST_IDX_W];
    end
  end

endmodule

// File: hawk_pgrd_ctrl.sv
////////////////////////////////////////////////////////////
// page-read control FSM: att read, decode, optional free-list
// allocation and table update, then one translation answer
////////////////////////////////////////////////////////////
module hawk_pgrd_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        lookup,
  output logic                        pgrd_ready,
  // datapath strobes
  output logic                        att_load,
  output logic                        head_load,
  output logic                        ent_load,
  output logic                        tol_load,
  output logic                        rd_start,
  output logic                        rd_sel,      // 0 att, 1 tol
  input  logic                        rd_done,
  input  logic                        rd_err,
  input  logic [hawk_pkg::STS_W-1:0]  ent_sts,
  input  logic [hawk_pkg::PAGE_W-1:0] ent_page,
  input  logic                        free_empty,
  input  logic [hawk_pkg::PAGE_W-1:0] upd_way,
  // page write manager
  input  logic                        pgwr_ready,
  output logic                        tbl_update,
  input  logic                        tbl_update_done,
  // answer
  output logic                        trnsl_valid,
  output logic [hawk_pkg::PAGE_W-1:0] trnsl_ppa,
  output logic [hawk_pkg::STS_W-1:0]  trnsl_sts,
  output logic                        trnsl_allow,
  output logic                        bus_error
);

  typedef enum logic [3:0] {
    IDLE, READ_ATT, WAIT_ATT, DECODE, POP_FREE,
    WAIT_TOL, UPDATE, WAIT_DONE, RESPOND, BUS_ERROR
  } state_t;

  state_t state_q, state_d;

  always_comb begin
    state_d    = state_q;
    att_load   = 1'b0;
    head_load  = 1'b0;
    ent_load   = 1'b0;
    tol_load   = 1'b0;
    rd_start   = 1'b0;
    tbl_update = 1'b0;
    case (state_q)
      IDLE: if (lookup) begin
        att_load = 1'b1;
        state_d  = READ_ATT;
      end
      READ_ATT: begin
        rd_start = 1'b1;  // att address selected
        state_d  = WAIT_ATT;
      end
      WAIT_ATT: if (rd_done) begin
        ent_load = !rd_err;
        state_d  = rd_err ? BUS_ERROR : DECODE;
      end
      DECODE: begin
        head_load = 1'b1;  // free head sampled on the way out
        state_d   = (ent_sts == hawk_pkg::STS_DALLOC) ? POP_FREE : RESPOND;
      end
      POP_FREE: begin
        rd_start = !free_empty;  // empty list answers at once
        state_d  = free_empty ? RESPOND : WAIT_TOL;
      end
      WAIT_TOL: if (rd_done) begin
        tol_load = !rd_err;
        state_d  = rd_err ? BUS_ERROR : UPDATE;
      end
      UPDATE: if (pgwr_ready) begin
        tbl_update = 1'b1;
        state_d    = WAIT_DONE;
      end
      WAIT_DONE: if (tbl_update_done) state_d = RESPOND;
      RESPOND:   state_d = IDLE;
      BUS_ERROR: state_d = BUS_ERROR;  // sticky until reset
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= IDLE;
    else         state_q <= state_d;
  end

  // answer payload, loaded on the way into RESPOND
  always_ff @(posedge clk_i) begin
    if (state_q == DECODE) begin
      trnsl_ppa   <= ent_page;
      trnsl_sts   <= ent_sts;
      trnsl_allow <= (ent_sts == hawk_pkg::STS_UNCOMP) || (ent_sts == hawk_pkg::STS_INCOMP);
    end else if (state_q == POP_FREE && free_empty) begin
      trnsl_ppa   <= '0;  // nothing free, compression not handled here
      trnsl_sts   <= hawk_pkg::STS_DALLOC;
      trnsl_allow <= 1'b0;
    end else if (state_q == WAIT_DONE && tbl_update_done) begin
      trnsl_ppa   <= upd_way;  // freshly allocated page
      trnsl_sts   <= hawk_pkg::STS_UNCOMP;
      trnsl_allow <= 1'b1;
    end
  end

  assign rd_sel      = (state_q == POP_FREE);
  assign pgrd_ready  = (state_q == IDLE);
  assign trnsl_valid = (state_q == RESPOND);
  assign bus_error   = (state_q == BUS_ERROR);

  // requester keeps one lookup in flight
  a_lookup_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lookup |-> pgrd_ready);
  // page write manager only answers an update in flight
  a_done_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl_update_done |-> (state_q == WAIT_DONE));

endmodule

// File: hawk_pgrd_top.sv
////////////////////////////////////////////////////////////
// page-read manager top: controller, axi read port and the
// att and tol datapaths; one lookup in flight at a time
////////////////////////////////////////////////////////////
module hawk_pgrd_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // lookup and answer
  input  logic                           lookup,
  input  logic [hawk_pkg::PAGE_W-1:0]    lookup_hppa,
  output logic                           pgrd_ready,
  output logic                           trnsl_valid,
  output logic [hawk_pkg::PAGE_W-1:0]    trnsl_ppa,
  output logic [hawk_pkg::STS_W-1:0]     trnsl_sts,
  output logic                           trnsl_allow,
  input  logic [hawk_pkg::LST_IDX_W-1:0] free_head,
  // axi read channel
  output logic                           arvalid,
  output logic [hawk_pkg::ADDR_W-1:0]    araddr,
  input  logic                           arready,
  input  logic                           rvalid,
  input  logic [hawk_pkg::DATA_W-1:0]    rdata,
  input  logic [hawk_pkg::RESP_W-1:0]    rresp,
  input  logic                           rlast,
  output logic                           rready,
  // page write manager
  input  logic                           pgwr_ready,
  output logic                           tbl_update,
  output logic [hawk_pkg::ATT_IDX_W-1:0] upd_att_idx,
  output logic [hawk_pkg::LST_IDX_W-1:0] upd_tol_idx,
  output logic [hawk_pkg::PAGE_W-1:0]    upd_way,
  output logic [hawk_pkg::LST_IDX_W-1:0] upd_next_head,
  input  logic                           tbl_update_done,
  output logic                           bus_error
);

  logic                        att_load, head_load, ent_load, tol_load;
  logic                        rd_start, rd_sel, rd_done, rd_err, free_empty;
  logic [hawk_pkg::ADDR_W-1:0] att_addr, tol_addr, rd_addr;
  logic [hawk_pkg::DATA_W-1:0] rd_data;
  logic [hawk_pkg::STS_W-1:0]  ent_sts;
  logic [hawk_pkg::PAGE_W-1:0] ent_page;

  assign rd_addr = rd_sel ? tol_addr : att_addr;  // one shared read port

  hawk_pgrd_ctrl ctrl_i (.*);
  hawk_axi_rd_port rd_port_i (.*);
  hawk_att_decoder att_dec_i (.*, .att_idx(upd_att_idx));
  hawk_tol_alloc tol_alloc_i (.*);

endmodule

// File: tb_hawk_pgrd.sv
////////////////////////////////////////////////////////////
// testbench for the page-read top: axi memory and page write
// models around the DUT, lookups and answers from the trace
////////////////////////////////////////////////////////////
module tb_hawk_pgrd;

  localparam int WAIT_LIMIT = 200;    // cycles per wait loop
  localparam int SEED       = 68907;

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  logic                           lookup, pgrd_ready, trnsl_valid, trnsl_allow, bus_error;
  logic [hawk_pkg::PAGE_W-1:0]    lookup_hppa, trnsl_ppa, upd_way;
  logic [hawk_pkg::STS_W-1:0]     trnsl_sts;
  logic [hawk_pkg::LST_IDX_W-1:0] free_head, upd_tol_idx, upd_next_head;
  logic [hawk_pkg::ATT_IDX_W-1:0] upd_att_idx;
  logic                           arvalid, arready, rvalid, rlast, rready;
  logic [hawk_pkg::ADDR_W-1:0]    araddr;
  logic [hawk_pkg::DATA_W-1:0]    rdata;
  logic [hawk_pkg::RESP_W-1:0]    rresp;
  logic                           pgwr_ready, tbl_update, tbl_update_done;

  logic [63:0] mem [bit [31:0]];  // memory image from M lines
  bit          err_addr [bit [31:0]];  // slverr addresses from E lines
  logic [31:0] ar_log [$];  // every accepted araddr, in order
  int          upd_n;  // table updates seen so far
  logic        upd_bad;
  logic [63:0] upd_seen [4];  // att idx, tol idx, way, next of the last update
  int          errors, timeouts;

  hawk_pgrd_top dut_i (.*);

  always #2 clk_i = ~clk_i;

  // axi slave, random arready, data 0 to 3 cycles after the address
  initial begin : axi_mem_model
    logic [31:0] addr_q;
    int          wait_q;
    logic        pend_q;
    logic        take_q;
    addr_q  = '0;
    wait_q  = 0;
    pend_q  = 1'b0;
    take_q  = 1'b0;
    arready = 1'b0;
    rvalid  = 1'b0;
    rlast   = 1'b0;
    rdata   = '0;
    rresp   = hawk_pkg::RESP_OKAY;
    forever begin
      @(negedge clk_i);
      rvalid = 1'b0;  // one-beat pulse, rready checked when raised
      rlast  = 1'b0;
      if (take_q) begin
        ar_log.push_back(addr_q);
        pend_q = 1'b1;
        wait_q = int'($urandom % 4);
      end
      if (pend_q && wait_q == 0) begin
        pend_q = 1'b0;
        rvalid = 1'b1;
        rlast  = 1'b1;
        rdata  = mem.exists(addr_q) ? mem[addr_q] : {~addr_q, addr_q};  // fill from address
        rresp  = err_addr.exists(addr_q) ? 2'b10 : hawk_pkg::RESP_OKAY;
        check_value("rready", 64'(rready), 64'd1);  // read outstanding, beat must pass
      end else if (pend_q) begin
        wait_q = wait_q - 1;
      end
      arready = rst_ni && ($urandom % 3 != 0);
      take_q  = arvalid && arready;  // handshake at the coming edge
      if (take_q) addr_q = araddr;
    end
  end

  // page write manager, random pgwr_ready, done 2 to 5 cycles after update
  initial begin : pgwr_model
    int done_cnt;
    done_cnt        = 0;
    upd_n           = 0;
    upd_bad         = 1'b0;
    pgwr_ready      = 1'b0;
    tbl_update_done = 1'b0;
    forever begin
      @(negedge clk_i);
      tbl_update_done = 1'b0;
      if (done_cnt > 0) begin
        done_cnt        = done_cnt - 1;
        tbl_update_done = (done_cnt == 0);
      end
      pgwr_ready = rst_ni && ($urandom % 4 != 0);
      #1;  // tbl_update follows pgwr_ready
      if (tbl_update) begin
        upd_n       = upd_n + 1;
        upd_bad     = upd_bad || !pgwr_ready;
        upd_seen[0] = 64'(upd_att_idx);
        upd_seen[1] = 64'(upd_tol_idx);
        upd_seen[2] = 64'(upd_way);
        upd_seen[3] = 64'(upd_next_head);
        done_cnt    = 2 + int'($urandom % 4);
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!pgrd_ready && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n = n + 1;
    end
    if (!pgrd_ready) begin
      timeouts = timeouts + 1;
      $display("timeout: pgrd_ready never came back high");
    end
  endtask

  // end of a lookup is an answer or a bus error
  task automatic wait_answer(input logic [31:0] page);
    int n;
    n = 0;
    while (!trnsl_valid && !bus_error && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n = n + 1;
    end
    if (!trnsl_valid && !bus_error) begin
      timeouts = timeouts + 1;
      $display("timeout: no answer and no bus error for page 0x%0h", page);
    end
  endtask

  initial begin : run_trace
    int               fd;
    int               n;
    int               ar0;
    int               up0;
    logic [7:0]       tag;
    logic [8*120-1:0] line;
    logic [31:0]      addr, idx, att_addr;
    logic [63:0]      data;
    logic [31:0]      page, head, upd, allow, sts, ppa, way, next;
    void'($urandom(SEED));
    errors      = 0;
    timeouts    = 0;
    rst_ni      = 1'b0;
    lookup      = 1'b0;
    lookup_hppa = '0;
    free_head   = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    fd = $fopen("pgrd_trace.txt", "r");
    if (fd == 0) begin
      errors = errors + 1;
      $display("could not open the trace file pgrd_trace.txt");
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "#") begin
          n = $fgets(line, fd);  // skip comment line
        end else if (tag == "M") begin
          n = $fscanf(fd, "%h %h", addr, data);
          mem[addr] = data;
        end else if (tag == "E") begin
          n = $fscanf(fd, "%h", addr);
          err_addr[addr] = 1'b1;
        end else if (tag == "L") begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h", page, head, upd, allow, sts, ppa, way, next);
          // entry number is page minus base page plus one
          idx      = (page - 32'(hawk_pkg::HPPA_BASE_PAGE) + 1)
                   & ((32'd1 << hawk_pkg::ATT_IDX_W) - 1);
          att_addr = hawk_pkg::ATT_BASE_ADDR + (idx << 3);
          wait_ready();
          ar0         = ar_log.size();
          up0         = upd_n;
          lookup      = 1'b1;
          lookup_hppa = page[hawk_pkg::PAGE_W-1:0];
          free_head   = head[hawk_pkg::LST_IDX_W-1:0];  // level, held until the next lookup
          @(negedge clk_i);
          lookup = 1'b0;
          wait_answer(page);
          check_value("att araddr", 64'(ar_log.size() > ar0 ? ar_log[ar0] : '1), 64'(att_addr));
          if (err_addr.exists(att_addr)) begin
            check_value("bus_error", 64'(bus_error), 64'd1);
            check_value("trnsl_valid", 64'(trnsl_valid), 64'd0);
            repeat (20) begin
              @(negedge clk_i);
              check_value("bus_error", 64'(bus_error), 64'd1);
              check_value("pgrd_ready", 64'(pgrd_ready), 64'd0);
              check_value("trnsl_valid", 64'(trnsl_valid), 64'd0);
            end
          end else begin
            check_value("trnsl_valid", 64'(trnsl_valid), 64'd1);
            check_value("trnsl_allow", 64'(trnsl_allow), 64'(allow));
            check_value("trnsl_sts", 64'(trnsl_sts), 64'(sts));
            check_value("trnsl_ppa", 64'(trnsl_ppa), 64'(ppa));
            check_value("read count", 64'(ar_log.size() - ar0), (upd != 0) ? 64'd2 : 64'd1);
            check_value("tbl_update count", 64'(upd_n - up0), 64'(upd));
            if (upd != 0 && ar_log.size() > ar0 + 1) begin
              check_value("tol araddr", 64'(ar_log[ar0+1]),
                          64'(hawk_pkg::TOL_BASE_ADDR + (head << 3)));
              check_value("upd_att_idx", upd_seen[0], 64'(idx));
              check_value("upd_tol_idx", upd_seen[1], 64'(head));
              check_value("upd_way", upd_seen[2], 64'(way));
              check_value("upd_next_head", upd_seen[3], 64'(next));
            end
            @(negedge clk_i);
            check_value("pgrd_ready", 64'(pgrd_ready), 64'd1);  // back one cycle after answer
          end
        end
      end
      $fclose(fd);
    end
    check_value("tbl_update without pgwr_ready", 64'(upd_bad), 64'd0);
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: pgrd_trace.txt
# M addr data | E addr (read answers slverr) | L page head upd allow sts ppa way next
# upd 1 expects a table update carrying way and next; every value in hex
M 00010008 0000000001234501
M 00010028 feed000000abcdfe
M 00010088 00000000000000f0
M 00020038 000000004a5b6009
M 00010108 00000000033333ff
M 00010090 0000000000000000
M 00010098 a5a5a5a500000004
M 00020048 123456784a5b7a00
E 00010188
L 80000 07 0 1 1 12345 0 0
L 80004 00 0 1 2 0abcd 0 0
L 80010 07 1 1 1 4a5b6 4a5b6 09
L 80020 09 0 0 3 33333 0 0
L 80011 00 0 0 0 00000 0 0
L 80012 09 1 1 1 4a5b7 4a5b7 00
L 80030 00 0 0 0 00000 0 0

// File: verilog.f
hawk_pkg.sv
hawk_axi_rd_port.sv
hawk_att_decoder.sv
hawk_tol_alloc.sv
hawk_pgrd_ctrl.sv
hawk_pgrd_top.sv
tb_hawk_pgrd.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_hawk_pgrd \
		-f verilog.f -Mdir obj_dir -o sim_hawk_pgrd
	./obj_dir/sim_hawk_pgrd > sim.log 2>&1 || true
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
